// ==== Makefile ====
# Verilator build and run of the cart controller testbench

SRCS := $(wildcard include/*.svh src/*.sv test/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_cart_top: src.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_cart_top -f src.f

run: obj_dir/Vtb_cart_top
	./obj_dir/Vtb_cart_top | tee sim.log
	grep -q "^STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== include/cart_config.svh ====
`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

// memory words actually decoded
`define CART_MEM_ABITS 10

// flow control depths
`define CART_HOST_CREDITS 4
`define CART_SD_CREDITS 2
`define CART_ARB_CREDITS 2

////////////////////////////////////////////////////////////
// command codes, upper nibble selects
`define CMD_SET_ADDR 4'h0
`define CMD_SET_MASK 4'h1
`define CMD_MAPPER 4'h3
`define CMD_DMA 4'h4
`define CMD_READ 4'h8
`define CMD_WRITE 4'h9
// full byte compare for these two
`define CMD_ECHO 8'hF0
`define CMD_STATUS 8'hF1

`endif

// ==== src.f ====
+incdir+include
src/cart_pkg.sv
src/cart_sram.sv
src/mem_arbiter.sv
src/sd_dma.sv
src/mcu_cmd.sv
src/cart_top.sv
test/clk_gen.sv
test/tb_cart_top.sv

// ==== src/cart_pkg.sv ====
`include "cart_config.svh"

package cart_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [23:0] addr_t;
  typedef logic [2:0] mapper_t;
  typedef logic [`CART_MEM_ABITS-1:0] mem_addr_t;
  typedef logic [15:0] len_t;

  ////////////////////////////////////////////////////////////
  // link payloads

  // first marks the command byte of a frame
  typedef struct packed {
    byte_t data;
    logic  first;
  } host_byte_t;

  typedef struct packed {
    mem_addr_t addr;
    byte_t     wdata;
    logic      write;
  } mem_req_t;

  // id 0 is the command interpreter, 1 the dma engine
  typedef struct packed {
    byte_t rdata;
    logic  id;
  } mem_rsp_t;

  ////////////////////////////////////////////////////////////
  // sequencer states

  typedef enum logic [1:0] {
    cmd_idle,
    cmd_param,
    cmd_read_wait
  } cmd_state_t;

  typedef enum logic {
    dma_idle,
    dma_run
  } dma_state_t;

endpackage

// ==== src/cart_sram.sv ====
`include "cart_config.svh"

module cart_sram (
  input  logic               clk,
  input  logic               mem_en,
  input  cart_pkg::mem_req_t mem_req,
  output cart_pkg::byte_t    mem_rdata
);
  import cart_pkg::*;

  byte_t mem [2**`CART_MEM_ABITS];

  // single port, read data one cycle after the enable
  always_ff @(posedge clk) begin
    if (mem_en) begin
      if (mem_req.write) begin
        mem[mem_req.addr] <= mem_req.wdata;
      end else begin
        mem_rdata <= mem[mem_req.addr];
      end
    end
  end

endmodule

// ==== src/cart_top.sv ====
module cart_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 host_valid,
  input  cart_pkg::host_byte_t host_byte,
  output logic                 host_credit,
  output logic                 rsp_valid,
  output cart_pkg::byte_t      rsp_byte,
  input  logic                 sd_valid,
  input  cart_pkg::byte_t      sd_data,
  output logic                 sd_credit,
  output cart_pkg::mapper_t    mapper,
  output cart_pkg::addr_t      rom_mask
);
  import cart_pkg::*;

  logic      m0_req_valid;
  mem_req_t  m0_req;
  logic      m0_req_credit;
  logic      m1_req_valid;
  mem_req_t  m1_req;
  logic      m1_req_credit;
  logic      arb_rsp_valid;
  mem_rsp_t  arb_rsp;
  logic      mem_en;
  mem_req_t  mem_req;
  byte_t     mem_rdata;
  logic      dma_start;
  mem_addr_t dma_addr;
  len_t      dma_len;
  logic      dma_busy;

  ////////////////////////////////////////////////////////////
  // memory masters

  mcu_cmd u_mcu_cmd (
    .clk           (clk),
    .rst_n         (rst_n),
    .host_valid    (host_valid),
    .host_byte     (host_byte),
    .host_credit   (host_credit),
    .rsp_valid     (rsp_valid),
    .rsp_byte      (rsp_byte),
    .mapper        (mapper),
    .rom_mask      (rom_mask),
    .req_valid     (m0_req_valid),
    .req           (m0_req),
    .req_credit    (m0_req_credit),
    .mem_rsp_valid (arb_rsp_valid),
    .mem_rsp       (arb_rsp),
    .dma_start     (dma_start),
    .dma_addr      (dma_addr),
    .dma_len       (dma_len),
    .dma_busy      (dma_busy)
  );

  sd_dma u_sd_dma (
    .clk        (clk),
    .rst_n      (rst_n),
    .sd_valid   (sd_valid),
    .sd_data    (sd_data),
    .sd_credit  (sd_credit),
    .dma_start  (dma_start),
    .dma_addr   (dma_addr),
    .dma_len    (dma_len),
    .dma_busy   (dma_busy),
    .req_valid  (m1_req_valid),
    .req        (m1_req),
    .req_credit (m1_req_credit)
  );

  ////////////////////////////////////////////////////////////
  // shared memory

  mem_arbiter u_mem_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .m0_req_valid  (m0_req_valid),
    .m0_req        (m0_req),
    .m0_req_credit (m0_req_credit),
    .m1_req_valid  (m1_req_valid),
    .m1_req        (m1_req),
    .m1_req_credit (m1_req_credit),
    .rsp_valid     (arb_rsp_valid),
    .rsp           (arb_rsp),
    .mem_en        (mem_en),
    .mem_req       (mem_req),
    .mem_rdata     (mem_rdata)
  );

  cart_sram u_cart_sram (
    .clk       (clk),
    .mem_en    (mem_en),
    .mem_req   (mem_req),
    .mem_rdata (mem_rdata)
  );

endmodule

// ==== src/mcu_cmd.sv ====
`include "cart_config.svh"

module mcu_cmd (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 host_valid,
  input  cart_pkg::host_byte_t host_byte,
  output logic                 host_credit,
  output logic                 rsp_valid,
  output cart_pkg::byte_t      rsp_byte,
  output cart_pkg::mapper_t    mapper,
  output cart_pkg::addr_t      rom_mask,
  output logic                 req_valid,
  output cart_pkg::mem_req_t   req,
  input  logic                 req_credit,
  input  logic                 mem_rsp_valid,
  input  cart_pkg::mem_rsp_t   mem_rsp,
  output logic                 dma_start,
  output cart_pkg::mem_addr_t  dma_addr,
  output cart_pkg::len_t       dma_len,
  input  logic                 dma_busy
);
  import cart_pkg::*;

  localparam int host_ptr_w = $clog2(`CART_HOST_CREDITS);
  localparam int arb_cnt_w = $clog2(`CART_ARB_CREDITS + 1);
  localparam byte_t echo_reply = 8'hA5;

  host_byte_t            fifo_mem [`CART_HOST_CREDITS];
  logic [host_ptr_w-1:0] fifo_wptr;
  logic [host_ptr_w-1:0] fifo_rptr;
  logic [host_ptr_w:0]   fifo_cnt;
  host_byte_t            cur;
  logic                  cur_valid;
  cmd_state_t            state;
  byte_t                 cmd;
  logic [1:0]            pcnt;
  addr_t                 addr;
  logic [arb_cnt_w-1:0]  arb_cnt;
  mem_addr_t             mem_addr;
  logic                  is_read_cmd;
  logic                  is_mem_cmd;
  logic                  is_reply_cmd;
  logic                  mem_param;
  logic                  fire;
  logic                  param_fire;
  logic                  issue;
  logic                  pop;
  logic                  rd_done;

  assign is_read_cmd = cmd[7:4] == `CMD_READ;
  assign is_mem_cmd = is_read_cmd || cmd[7:4] == `CMD_WRITE;
  assign is_reply_cmd = cmd == `CMD_ECHO || cmd == `CMD_STATUS;
  assign mem_addr = mem_addr_t'(addr & rom_mask);

  // a memory parameter waits for an arbiter credit
  assign mem_param = cur_valid && !cur.first && state == cmd_param && is_mem_cmd;
  assign fire = cur_valid && state != cmd_read_wait && !(mem_param && arb_cnt == '0);
  assign param_fire = fire && !cur.first && state == cmd_param;
  assign issue = fire && mem_param;
  assign rd_done = state == cmd_read_wait && mem_rsp_valid && !mem_rsp.id;

  // hold off the next byte while a read is in flight
  assign pop = fifo_cnt != '0 && state != cmd_read_wait && (!cur_valid || fire) &&
               !(issue && is_read_cmd);

  ////////////////////////////////////////////////////////////
  // host byte fifo

  always_ff @(posedge clk) begin
    if (host_valid) begin
      fifo_mem[fifo_wptr] <= host_byte;
    end
    if (pop) begin
      cur <= fifo_mem[fifo_rptr];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fifo_wptr   <= '0;
      fifo_rptr   <= '0;
      fifo_cnt    <= '0;
      host_credit <= 1'b0;
      cur_valid   <= 1'b0;
    end else begin
      host_credit <= pop;
      if (host_valid) begin
        fifo_wptr <= fifo_wptr + 1'b1;
      end
      if (pop) begin
        fifo_rptr <= fifo_rptr + 1'b1;
      end
      if (host_valid && !pop) begin
        fifo_cnt <= fifo_cnt + 1'b1;
      end else if (!host_valid && pop) begin
        fifo_cnt <= fifo_cnt - 1'b1;
      end
      if (pop) begin
        cur_valid <= 1'b1;
      end else if (fire) begin
        cur_valid <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // command sequencer

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= cmd_idle;
      cmd       <= '0;
      pcnt      <= '0;
      addr      <= '0;
      rom_mask  <= '1;
      mapper    <= '0;
      rsp_valid <= 1'b0;
      req_valid <= 1'b0;
      dma_start <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;
      req_valid <= 1'b0;
      dma_start <= 1'b0;
      if (fire && cur.first) begin
        cmd   <= cur.data;
        pcnt  <= '0;
        state <= cmd_param;
        if (cur.data[7:4] == `CMD_MAPPER) begin
          mapper <= cur.data[2:0];
        end
      end else if (param_fire) begin
        if (pcnt != 2'd3) begin
          pcnt <= pcnt + 1'b1;
        end
        if (is_reply_cmd) begin
          rsp_valid <= 1'b1;
        end else begin
          case (cmd[7:4])
            // high byte first, clears the rest
            `CMD_SET_ADDR: begin
              case (pcnt)
                2'd0: addr <= {cur.data, 16'h0000};
                2'd1: addr[15:8] <= cur.data;
                2'd2: addr[7:0] <= cur.data;
                default: ;
              endcase
            end
            `CMD_SET_MASK: begin
              case (pcnt)
                2'd0: rom_mask <= {cur.data, 16'h0000};
                2'd1: rom_mask[15:8] <= cur.data;
                2'd2: rom_mask[7:0] <= cur.data;
                default: ;
              endcase
            end
            `CMD_DMA: begin
              if (pcnt == 2'd1) begin
                dma_start <= 1'b1;
              end
            end
            `CMD_READ: begin
              req_valid <= 1'b1;
              addr      <= addr + 1'b1;
              state     <= cmd_read_wait;
            end
            `CMD_WRITE: begin
              req_valid <= 1'b1;
              addr      <= addr + 1'b1;
            end
            default: ;
          endcase
        end
      end else if (rd_done) begin
        rsp_valid <= 1'b1;
        state     <= cmd_param;
      end
    end
  end

  // reply data, memory request and dma setup
  always_ff @(posedge clk) begin
    if (param_fire && cmd == `CMD_STATUS) begin
      rsp_byte <= {dma_busy, 4'b0000, mapper};
    end else if (param_fire && cmd == `CMD_ECHO) begin
      rsp_byte <= echo_reply;
    end else if (rd_done) begin
      rsp_byte <= mem_rsp.rdata;
    end
    if (issue) begin
      req.addr  <= mem_addr;
      req.wdata <= cur.data;
      req.write <= !is_read_cmd;
    end
    if (param_fire && cmd[7:4] == `CMD_DMA) begin
      if (pcnt == 2'd0) begin
        dma_len[15:8] <= cur.data;
      end else begin
        dma_len[7:0] <= cur.data;
        dma_addr     <= mem_addr;
      end
    end
  end

  // arbiter credits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arb_cnt <= arb_cnt_w'(`CART_ARB_CREDITS);
    end else begin
      case ({issue, req_credit})
        2'b10: arb_cnt <= arb_cnt - 1'b1;
        2'b01: arb_cnt <= arb_cnt + 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// ==== src/mem_arbiter.sv ====
`include "cart_config.svh"

module mem_arbiter (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               m0_req_valid,
  input  cart_pkg::mem_req_t m0_req,
  output logic               m0_req_credit,
  input  logic               m1_req_valid,
  input  cart_pkg::mem_req_t m1_req,
  output logic               m1_req_credit,
  output logic               rsp_valid,
  output cart_pkg::mem_rsp_t rsp,
  output logic               mem_en,
  output cart_pkg::mem_req_t mem_req,
  input  cart_pkg::byte_t    mem_rdata
);
  import cart_pkg::*;

  localparam int q_ptr_w = $clog2(`CART_ARB_CREDITS);

  mem_req_t           q_mem [2][`CART_ARB_CREDITS];
  logic [q_ptr_w-1:0] wptr [2];
  logic [q_ptr_w-1:0] rptr [2];
  logic [q_ptr_w:0]   q_cnt [2];
  mem_req_t           push_req [2];
  logic [1:0]         push;
  logic [1:0]         pop;
  logic [1:0]         nonempty;
  logic               prio;
  logic               grant_id;
  logic               rd_id;

  assign push = {m1_req_valid, m0_req_valid};
  assign push_req[0] = m0_req;
  assign push_req[1] = m1_req;

  always_comb begin
    for (int m = 0; m < 2; m++) begin
      nonempty[m] = q_cnt[m] != '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // round robin grant, one queue per cycle

  assign grant_id = nonempty[prio] ? prio : ~prio;
  assign mem_en = |nonempty;
  assign pop[0] = mem_en && !grant_id;
  assign pop[1] = mem_en && grant_id;
  assign mem_req = q_mem[grant_id][rptr[grant_id]];

  // read data is registered in the sram, id follows it
  assign rsp.rdata = mem_rdata;
  assign rsp.id = rd_id;

  always_ff @(posedge clk) begin
    for (int m = 0; m < 2; m++) begin
      if (push[m]) begin
        q_mem[m][wptr[m]] <= push_req[m];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int m = 0; m < 2; m++) begin
        wptr[m]  <= '0;
        rptr[m]  <= '0;
        q_cnt[m] <= '0;
      end
      prio          <= 1'b0;
      rd_id         <= 1'b0;
      rsp_valid     <= 1'b0;
      m0_req_credit <= 1'b0;
      m1_req_credit <= 1'b0;
    end else begin
      for (int m = 0; m < 2; m++) begin
        if (push[m]) begin
          wptr[m] <= wptr[m] + 1'b1;
        end
        if (pop[m]) begin
          rptr[m] <= rptr[m] + 1'b1;
        end
        if (push[m] && !pop[m]) begin
          q_cnt[m] <= q_cnt[m] + 1'b1;
        end else if (!push[m] && pop[m]) begin
          q_cnt[m] <= q_cnt[m] - 1'b1;
        end
      end
      // loser of this grant goes first next time
      if (mem_en) begin
        prio <= ~grant_id;
      end
      rsp_valid     <= mem_en && !mem_req.write;
      rd_id         <= grant_id;
      m0_req_credit <= pop[0];
      m1_req_credit <= pop[1];
    end
  end

endmodule

// ==== src/sd_dma.sv ====
`include "cart_config.svh"

module sd_dma (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                sd_valid,
  input  cart_pkg::byte_t     sd_data,
  output logic                sd_credit,
  input  logic                dma_start,
  input  cart_pkg::mem_addr_t dma_addr,
  input  cart_pkg::len_t      dma_len,
  output logic                dma_busy,
  output logic                req_valid,
  output cart_pkg::mem_req_t  req,
  input  logic                req_credit
);
  import cart_pkg::*;

  localparam int sd_ptr_w = $clog2(`CART_SD_CREDITS);
  localparam int arb_cnt_w = $clog2(`CART_ARB_CREDITS + 1);

  byte_t                buf_mem [`CART_SD_CREDITS];
  logic [sd_ptr_w-1:0]  wptr;
  logic [sd_ptr_w-1:0]  rptr;
  logic [sd_ptr_w:0]    buf_cnt;
  dma_state_t           state;
  mem_addr_t            addr;
  len_t                 remaining;
  logic [arb_cnt_w-1:0] arb_cnt;
  logic                 issue;
  logic                 drained;

  assign issue = state == dma_run && remaining != '0 && buf_cnt != '0 && arb_cnt != '0;
  // every write handed back its credit, so all were granted
  assign drained = remaining == '0 && arb_cnt == arb_cnt_w'(`CART_ARB_CREDITS);
  assign dma_busy = state == dma_run;

  always_ff @(posedge clk) begin
    if (sd_valid) begin
      buf_mem[wptr] <= sd_data;
    end
    if (state == dma_idle && dma_start) begin
      addr <= dma_addr;
    end else if (issue) begin
      addr <= addr + 1'b1;
    end
    if (issue) begin
      req.addr  <= addr;
      req.wdata <= buf_mem[rptr];
      req.write <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr      <= '0;
      rptr      <= '0;
      buf_cnt   <= '0;
      state     <= dma_idle;
      remaining <= '0;
      arb_cnt   <= arb_cnt_w'(`CART_ARB_CREDITS);
      sd_credit <= 1'b0;
      req_valid <= 1'b0;
    end else begin
      sd_credit <= issue;
      req_valid <= issue;
      if (sd_valid) begin
        wptr <= wptr + 1'b1;
      end
      if (issue) begin
        rptr      <= rptr + 1'b1;
        remaining <= remaining - 1'b1;
      end
      if (sd_valid && !issue) begin
        buf_cnt <= buf_cnt + 1'b1;
      end else if (!sd_valid && issue) begin
        buf_cnt <= buf_cnt - 1'b1;
      end
      case ({issue, req_credit})
        2'b10: arb_cnt <= arb_cnt - 1'b1;
        2'b01: arb_cnt <= arb_cnt + 1'b1;
        default: ;
      endcase
      case (state)
        dma_idle: begin
          if (dma_start) begin
            remaining <= dma_len;
            state     <= dma_run;
          end
        end
        dma_run: begin
          if (drained) begin
            state <= dma_idle;
          end
        end
        default: state <= dma_idle;
      endcase
    end
  end

endmodule

// ==== test/cart_testdata.txt ====
# columns: test name, operation, hex value
# H host byte (bit 8 marks a command byte), S sd byte, E reply listed before its trigger,
# P mapper, K rom mask, W poll status until the dma engine is idle
status_reset E 00
status_reset H 1f1
status_reset H 00
echo E a5
echo E a5
echo H 1f0
echo H 11
echo H 22
mapper H 135
mapper P 5
mask_order H 110
mask_order H 12
mask_order K 120000
mask_order H 34
mask_order H 56
mask_order K 123456
mask_narrow H 110
mask_narrow H 00
mask_narrow H 00
mask_narrow H ff
mask_narrow K 0000ff
write_read H 100
write_read H 00
write_read H 190
write_read H 11
write_read H 22
write_read H 33
write_read H 100
write_read H 00
write_read E 11
write_read E 22
write_read E 33
write_read H 180
write_read H 00
write_read H 00
write_read H 00
alias H 100
alias H 01
alias H 190
alias H c3
alias H 100
alias H 00
alias E c3
alias H 180
alias H 00
dma H 100
dma H 00
dma H 40
dma H 140
dma H 00
dma H 03
dma S 10
dma E a5
dma H 1f0
dma H 01
dma S 20
dma S 30
dma W 00
dma_read H 100
dma_read H 00
dma_read H 40
dma_read E 10
dma_read E 20
dma_read E 30
dma_read H 180
dma_read H 00
dma_read H 00
dma_read H 00

// ==== test/clk_gen.sv ====
module clk_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

// ==== test/tb_cart_top.sv ====
`include "cart_config.svh"

module tb_cart_top;
  timeunit 1ns;
  timeprecision 100ps;
  import cart_pkg::*;

  localparam int exp_depth = 1024;
  localparam int idle_limit = 200;

  logic       clk;
  logic       rst_n;
  logic       host_valid;
  host_byte_t host_byte;
  logic       host_credit;
  logic       rsp_valid;
  byte_t      rsp_byte;
  logic       sd_valid;
  byte_t      sd_data;
  logic       sd_credit;
  mapper_t    mapper;
  addr_t      rom_mask;

  // parsed data file
  string       op_name [$];
  logic [7:0]  op_code [$];
  logic [31:0] op_val [$];

  // expected replies, written by the stimulus side, read by the monitor
  string exp_name [exp_depth];
  byte_t exp_val [exp_depth];
  logic  exp_poll [exp_depth];
  int    exp_wr = 0;
  int    exp_rd = 0;

  int    host_sent = 0;
  int    host_back = 0;
  int    sd_sent = 0;
  int    sd_back = 0;
  int    seed = 40;
  int    cycle_limit = 0;
  byte_t last_status = 8'hff;
  int    reply_mismatches = 0;
  int    value_mismatches = 0;
  int    extra_replies = 0;
  int    main_errors = 0;

  clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  cart_top uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .host_valid  (host_valid),
    .host_byte   (host_byte),
    .host_credit (host_credit),
    .rsp_valid   (rsp_valid),
    .rsp_byte    (rsp_byte),
    .sd_valid    (sd_valid),
    .sd_data     (sd_data),
    .sd_credit   (sd_credit),
    .mapper      (mapper),
    .rom_mask    (rom_mask)
  );

  ////////////////////////////////////////////////////////////
  // compare tasks

  task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
    if (actual !== expected) begin
      reply_mismatches++;
      $display("Mismatch in %s: expected 0x%h, actual 0x%h", name, expected, actual);
    end
  endtask

  task automatic check_mapper(input string name, input mapper_t expected,
                              input mapper_t actual);
    if (actual !== expected) begin
      value_mismatches++;
      $display("Mismatch in %s: expected mapper %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic check_mask(input string name, input addr_t expected, input addr_t actual);
    if (actual !== expected) begin
      value_mismatches++;
      $display("Mismatch in %s: expected mask 0x%h, actual 0x%h", name, expected, actual);
    end
  endtask

  task automatic finish_run(input logic timed_out);
    int mismatches;
    int others;
    mismatches = reply_mismatches + value_mismatches;
    others = main_errors + extra_replies + (timed_out ? 1 : 0);
    $display("mismatches: %0d, other errors: %0d", mismatches, others);
    if (mismatches == 0 && others == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus

  task automatic load_tests();
    int    fd;
    int    n;
    string line;
    string name;
    string op;
    logic [31:0] val;
    fd = $fopen("test/cart_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open test/cart_testdata.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // skip blank and comment lines
        if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %s %h", name, op, val);
          if (n == 3) begin
            op_name.push_back(name);
            op_code.push_back(op.getc(0));
            op_val.push_back(val);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic send_host(input logic first, input byte_t data);
    while (host_sent - host_back >= `CART_HOST_CREDITS) begin
      @(posedge clk);
      #1;
    end
    host_valid = 1'b1;
    host_byte.data = data;
    host_byte.first = first;
    host_sent++;
    @(posedge clk);
    #1;
    host_valid = 1'b0;
  endtask

  task automatic send_sd(input byte_t data);
    int gap;
    // random idle cycles between sd bytes
    gap = $unsigned($random(seed)) % 3;
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    while (sd_sent - sd_back >= `CART_SD_CREDITS) begin
      @(posedge clk);
      #1;
    end
    sd_valid = 1'b1;
    sd_data = data;
    sd_sent++;
    @(posedge clk);
    #1;
    sd_valid = 1'b0;
  endtask

  task automatic expect_reply(input string name, input byte_t value, input logic poll);
    exp_name[exp_wr % exp_depth] = name;
    exp_val[exp_wr % exp_depth] = value;
    exp_poll[exp_wr % exp_depth] = poll;
    exp_wr++;
  endtask

  // all host bytes consumed and all replies in
  task automatic wait_idle(input string name);
    int waited;
    waited = 0;
    while ((exp_rd != exp_wr || host_sent != host_back) && waited < idle_limit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (exp_rd != exp_wr) begin
      main_errors++;
      $display("%s: %0d expected replies never arrived", name, exp_wr - exp_rd);
      exp_wr = exp_rd;
    end else if (host_sent != host_back) begin
      main_errors++;
      $display("%s: host bytes were never taken by the DUT", name);
    end
    repeat (4) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_tests();
    logic busy;
    for (int i = 0; i < op_name.size(); i++) begin
      case (op_code[i])
        "H": send_host(op_val[i][8], op_val[i][7:0]);
        "S": send_sd(op_val[i][7:0]);
        "E": expect_reply(op_name[i], op_val[i][7:0], 1'b0);
        "P": begin
          wait_idle(op_name[i]);
          check_mapper(op_name[i], op_val[i][2:0], mapper);
        end
        "K": begin
          wait_idle(op_name[i]);
          check_mask(op_name[i], op_val[i][23:0], rom_mask);
        end
        "W": begin
          // poll status until the dma engine is idle
          busy = 1'b1;
          while (busy) begin
            expect_reply(op_name[i], 8'h00, 1'b1);
            send_host(1'b1, `CMD_STATUS);
            send_host(1'b0, 8'h00);
            wait_idle(op_name[i]);
            busy = last_status[7];
          end
        end
        default: begin
          main_errors++;
          $display("unknown operation %c in %s", op_code[i], op_name[i]);
        end
      endcase
    end
  endtask

  initial begin
    host_valid = 1'b0;
    host_byte = '0;
    sd_valid = 1'b0;
    sd_data = '0;
    load_tests();
    cycle_limit = 200 * op_name.size() + 20;
    wait (rst_n === 1'b1);
    @(posedge clk);
    #1;
    if (op_name.size() == 0) begin
      main_errors++;
      $display("no test data was read");
    end else begin
      run_tests();
      wait_idle("end of run");
      if (sd_sent != sd_back) begin
        main_errors++;
        $display("end of run: %0d sd bytes sent but %0d sd credits returned",
                 sd_sent, sd_back);
      end
    end
    finish_run(1'b0);
  end

  ////////////////////////////////////////////////////////////
  // credits and replies

  always @(posedge clk) begin
    if (rst_n) begin
      if (host_credit) begin
        host_back++;
      end
      if (sd_credit) begin
        sd_back++;
      end
      if (rsp_valid) begin
        if (exp_rd == exp_wr) begin
          extra_replies++;
          $display("unexpected reply 0x%h arrived with none outstanding", rsp_byte);
        end else begin
          if (exp_poll[exp_rd % exp_depth]) begin
            last_status = rsp_byte;
          end else begin
            check_byte(exp_name[exp_rd % exp_depth], exp_val[exp_rd % exp_depth], rsp_byte);
          end
          exp_rd++;
        end
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    wait (cycle_limit != 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycles);
    finish_run(1'b1);
  end

endmodule
